//--- stBlitter.f
src/blitRegsPkg.sv
src/blitCorePkg.sv
src/blitRegisterFile.sv
src/blitAddrGen.sv
src/blitSequencer.sv
src/blitDataPath.sv
src/stBlitter.sv
tb/stBlitterTb.sv

//--- run.sh
#!/bin/sh
# Builds the blitter testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	-f stBlitter.f --top-module stBlitterTb
out=$(./obj_dir/VstBlitterTb)
echo "$out"
echo "$out" | grep -qx "TEST OK"

//--- tb/stBlitterTb.sv
// Testbench for the blitter. Checks register read-back, then runs random blits with random
// memory latency against a reference model of memory, bus cycles and end registers.

`default_nettype none

module stBlitterTb;
	timeunit 1ns;
	timeprecision 1ns;
	import blitRegsPkg::*;

	localparam int numBlits = 40;
	localparam int memWords = 1024;	// Memory index is the low 10 word address bits
	localparam int timeoutCycles = numBlits * 12 * 4 * 5 + 1000;

	logic Clks = 1'b0;
	logic rst, cpuSel, cpuWr, memAck, busy, memReq, memWe;
	regIdx_t cpuIdx;
	logic [dataWidth-1:0] cpuWrData, cpuRdData, memRdData, memWrData;
	logic [addrWidth-1:0] memAddr;

	logic [dataWidth-1:0] mem [memWords];	// Memory behind the DUT
	logic [dataWidth-1:0] refMem [memWords];	// Reference model copy
	logic [2*dataWidth-1:0] refBuf = '0;	// Model skew buffer kept across blits
	logic [addrWidth-1:0] refSa, refDa;
	logic [3:0] bOp, bSkew;
	logic [dataWidth-1:0] bLeft, bCenter, bRight, bSxi, bSyi, bDxi, bDyi;
	int bW, bH, refReads, busReads, busWrites;
	logic slowMem;
	int errCount [3] = '{0, 0, 0};	// Registers, memory, bus

	stBlitter stBlitter_inst (.*);

	always #50 Clks = ~Clks;

	task automatic compareValue(input int kind, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			errCount[kind]++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic cpuWrite(input regIdx_t idx, input logic [dataWidth-1:0] data);
		cpuSel = 1'b1;
		cpuWr = 1'b1;
		cpuIdx = idx;
		cpuWrData = data;
		@(negedge Clks);
		cpuSel = 1'b0;
		cpuWr = 1'b0;
	endtask

	task automatic cpuRead(input regIdx_t idx, output logic [dataWidth-1:0] data);
		cpuSel = 1'b1;
		cpuWr = 1'b0;
		cpuIdx = idx;
		@(negedge Clks);
		cpuSel = 1'b0;
		data = cpuRdData;	// Registered on the edge after the strobe
	endtask

	// Acks after 0 to 3 wait cycles in slow mode and checks that the request holds
	initial begin : memoryModel
		logic inCycle;
		int waitLeft;
		logic [addrWidth-1:0] holdAddr;
		logic holdWe;
		logic [dataWidth-1:0] holdData;
		inCycle = 1'b0;
		waitLeft = 0;
		forever begin
			@(negedge Clks);
			if (memAck) begin
				memAck = 1'b0;
			end else if (memReq) begin
				if (!inCycle) begin
					inCycle = 1'b1;
					holdAddr = memAddr;
					holdWe = memWe;
					holdData = memWrData;
					waitLeft = slowMem ? int'($urandom % 4) : 0;
				end else begin
					compareValue(2, "memAddr", 32'(memAddr), 32'(holdAddr));
					compareValue(2, "memWe", 32'(memWe), 32'(holdWe));
					compareValue(2, "memWrData", 32'(memWrData), 32'(holdData));
				end
				if (waitLeft == 0) begin
					if (memWe) begin
						mem[memAddr[9:0]] = memWrData;
						busWrites++;
					end else begin
						memRdData = mem[memAddr[9:0]];
						busReads++;
					end
					memAck = 1'b1;
					inCycle = 1'b0;
				end else begin
					waitLeft--;
				end
			end
		end
	end

	function automatic logic [addrWidth-1:0] stepAddr(input logic [addrWidth-1:0] a,
		input logic [dataWidth-1:0] byteInc);
		return a + addrWidth'(int'($signed(byteInc)) / 2);	// Byte increment in words
	endfunction

	// Reference blit over refMem in the same per-word order as the bus cycles
	task automatic modelBlit();
		logic [dataWidth-1:0] mask, srcWord, dstWord, res;
		logic lastX, usesSrc, usesDst;
		int s, d;
		dstWord = '0;
		refReads = 0;
		usesSrc = (bOp[2] != bOp[0]) || (bOp[3] != bOp[1]);
		for (int y = 0; y < bH; y++) begin
			for (int x = 0; x < bW; x++) begin
				lastX = (x == bW - 1);
				mask = (x == 0) ? bLeft : (lastX ? bRight : bCenter);
				usesDst = (bOp[3] != bOp[2]) || (bOp[1] != bOp[0]) || mask != 16'hFFFF;
				if (usesSrc) begin
					srcWord = refMem[refSa[9:0]];
					refBuf = bSxi[15] ? {srcWord, refBuf[31:16]} : {refBuf[15:0], srcWord};
					refSa = stepAddr(refSa, lastX ? bSyi : bSxi);
					refReads++;
				end
				if (usesDst) begin
					dstWord = refMem[refDa[9:0]];
					refReads++;
				end
				srcWord = 16'(refBuf >> bSkew);
				for (int i = 0; i < dataWidth; i++) begin
					s = int'(srcWord[i]);
					d = int'(dstWord[i]);
					res[i] = mask[i] ? bOp[3 - 2 * s - d] : dstWord[i];
				end
				refMem[refDa[9:0]] = res;
				refDa = stepAddr(refDa, lastX ? bDyi : bDxi);
			end
		end
	endtask

	task automatic registerReadback();
		logic [dataWidth-1:0] wrVal [16];
		logic [dataWidth-1:0] expVal, rd;
		for (int i = 0; i < 16; i++) begin
			wrVal[i] = 16'($urandom);
			if (regIdx_t'(i) == regControl)
				wrVal[i][ctrlBusyBit] = 1'b0;	// Engine stays stopped
			cpuWrite(regIdx_t'(i), wrVal[i]);
		end
		for (int i = 0; i < 16; i++) begin
			case (regIdx_t'(i))
				regSrcAddrHi, regDstAddrHi: expVal = {8'h00, wrVal[i][7:0]};
				regSrcAddrLo, regDstAddrLo: expVal = wrVal[i] & 16'hFFFE;
				regOp, regControl:          expVal = wrVal[i] & 16'h000F;
				4'hF:                       expVal = '0;
				default:                    expVal = wrVal[i];
			endcase
			cpuRead(regIdx_t'(i), rd);
			compareValue(0, $sformatf("register %h", i), 32'(rd), 32'(expVal));
		end
	endtask

	function automatic logic [dataWidth-1:0] randMask();
		return ($urandom % 3 == 0) ? 16'hFFFF : 16'($urandom);
	endfunction

	task automatic runBlit(input int n);
		logic [dataWidth-1:0] rd;
		slowMem = n[0];	// Odd blits see random ack delays
		bOp = 4'($urandom);
		bSkew = 4'($urandom);
		bLeft = randMask();
		bCenter = randMask();
		bRight = randMask();
		bW = 1 + int'($urandom % 4);
		bH = 1 + int'($urandom % 3);
		bSxi = ($urandom % 2 == 0) ? 16'h0002 : 16'hFFFE;
		bDxi = ($urandom % 2 == 0) ? 16'h0002 : 16'hFFFE;
		bSyi = 16'((int'($urandom % 33) - 16) * 2);
		bDyi = 16'((int'($urandom % 33) - 16) * 2);
		refSa = addrWidth'($urandom);
		refDa = addrWidth'($urandom);
		cpuWrite(regSrcXinc, bSxi);
		cpuWrite(regSrcYinc, bSyi);
		cpuWrite(regDstXinc, bDxi);
		cpuWrite(regDstYinc, bDyi);
		cpuWrite(regLeftMask, bLeft);
		cpuWrite(regCenterMask, bCenter);
		cpuWrite(regRightMask, bRight);
		cpuWrite(regSrcAddrHi, 16'(refSa[22:15]));
		cpuWrite(regSrcAddrLo, {refSa[14:0], 1'b0});
		cpuWrite(regDstAddrHi, 16'(refDa[22:15]));
		cpuWrite(regDstAddrLo, {refDa[14:0], 1'b0});
		cpuWrite(regOp, 16'(bOp));
		cpuWrite(regXCount, 16'(bW));
		cpuWrite(regYCount, 16'(bH));
		busReads = 0;
		busWrites = 0;
		cpuWrite(regControl, 16'h8000 | 16'(bSkew));
		compareValue(0, "busy", 32'(busy), 32'd1);
		modelBlit();
		while (busy)
			@(negedge Clks);
		// Busy must fall right after the last word is written
		compareValue(2, "write cycles", 32'(busWrites), 32'(bW * bH));
		compareValue(2, "read cycles", 32'(busReads), 32'(refReads));
		cpuRead(regYCount, rd);
		compareValue(0, "yCount", 32'(rd), 32'd0);
		cpuRead(regXCount, rd);
		compareValue(0, "xCount", 32'(rd), 32'(bW));
		cpuRead(regSrcAddrHi, rd);
		compareValue(0, "srcAddrHi", 32'(rd), 32'(refSa[22:15]));
		cpuRead(regSrcAddrLo, rd);
		compareValue(0, "srcAddrLo", 32'(rd), 32'({refSa[14:0], 1'b0}));
		cpuRead(regDstAddrHi, rd);
		compareValue(0, "dstAddrHi", 32'(rd), 32'(refDa[22:15]));
		cpuRead(regDstAddrLo, rd);
		compareValue(0, "dstAddrLo", 32'(rd), 32'({refDa[14:0], 1'b0}));
		for (int i = 0; i < memWords; i++)
			compareValue(1, $sformatf("mem[%0d]", i), 32'(mem[i]), 32'(refMem[i]));
		refMem = mem;	// Next blit's model starts from the DUT memory
	endtask

	initial begin
		void'($urandom(32'h517b));
		rst = 1'b1;
		cpuSel = 1'b0;
		cpuWr = 1'b0;
		cpuIdx = '0;
		cpuWrData = '0;
		memAck = 1'b0;
		memRdData = '0;
		slowMem = 1'b0;
		foreach (mem[i])
			mem[i] = 16'($urandom);
		refMem = mem;
		repeat (5) @(negedge Clks);
		rst = 1'b0;
		registerReadback();
		for (int n = 0; n < numBlits; n++)
			runBlit(n);
		$display("errors: registers %0d, memory %0d, bus %0d",
			errCount[0], errCount[1], errCount[2]);
		if (errCount[0] + errCount[1] + errCount[2] == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin : watchdog
		#(timeoutCycles * 100);
		$display("watchdog expired before all blits finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/stBlitter.sv
// Blitter top level: CPU register port on plain strobes, memory master port
// with request/acknowledge. Connects registers, counters, sequencer and data path.

`default_nettype none

module stBlitter (
	input  wire logic Clks,
	input  wire logic rst,
	input  wire logic cpuSel,
	input  wire logic cpuWr,
	input  wire blitRegsPkg::regIdx_t cpuIdx,
	input  wire logic [blitRegsPkg::dataWidth-1:0] cpuWrData,
	input  wire logic memAck,
	input  wire logic [blitRegsPkg::dataWidth-1:0] memRdData,
	output logic [blitRegsPkg::dataWidth-1:0] cpuRdData,
	output logic busy,
	output logic memReq,
	output logic memWe,
	output logic [blitRegsPkg::addrWidth-1:0] memAddr,
	output logic [blitRegsPkg::dataWidth-1:0] memWrData
);
	import blitRegsPkg::*;
	import blitCorePkg::*;

	logic [opWidth-1:0] op;
	logic [skewWidth-1:0] skew;
	logic [dataWidth-1:0] leftMask, centerMask, rightMask;
	logic [dataWidth-1:0] srcXinc, srcYinc, dstXinc, dstYinc;
	logic [addrWidth-1:0] srcAddr, dstAddr;
	logic [dataWidth-1:0] xCount, yCount;
	logic [dataWidth-1:0] result;
	logic regWrEn, newBlit, firstWord, lastWord, blitEnd;
	logic srcDone, dstRdDone, wrDone, partialMask;
	logic direction, blitDone;

	assign direction = srcXinc[dataWidth-1];	// Source walks backwards
	assign blitDone = wrDone && blitEnd;

	blitRegisterFile regFile_inst (.Clks, .rst, .cpuSel, .cpuWr, .cpuIdx, .cpuWrData,
		.blitDone, .srcAddr, .dstAddr, .xCount, .yCount, .cpuRdData, .busy, .op, .skew,
		.leftMask, .centerMask, .rightMask, .srcXinc, .srcYinc, .dstXinc, .dstYinc,
		.regWrEn);

	blitAddrGen addrGen_inst (.Clks, .rst, .regWrEn, .cpuIdx, .cpuWrData, .srcXinc,
		.srcYinc, .dstXinc, .dstYinc, .srcDone, .wrDone, .srcAddr, .dstAddr, .xCount,
		.yCount, .firstWord, .lastWord, .blitEnd, .newBlit);

	blitSequencer sequencer_inst (.Clks, .rst, .busy, .newBlit, .op, .partialMask, .memAck,
		.srcAddr, .dstAddr, .result, .memReq, .memWe, .memAddr, .memWrData, .srcDone,
		.dstRdDone, .wrDone);

	blitDataPath dataPath_inst (.Clks, .rst, .srcDone, .dstRdDone, .memRdData, .op, .skew,
		.direction, .firstWord, .lastWord, .leftMask, .centerMask, .rightMask, .result,
		.partialMask);

endmodule

`default_nettype wire

//--- src/blitDataPath.sv
// Blitter data path: skew buffer, endmask choice, destination latch and logic op.
// The result is combinational from registered buffers and feeds the write cycle.

`default_nettype none

module blitDataPath (
	input  wire logic Clks,
	input  wire logic rst,
	input  wire logic srcDone,
	input  wire logic dstRdDone,
	input  wire logic [blitRegsPkg::dataWidth-1:0] memRdData,
	input  wire logic [blitCorePkg::opWidth-1:0] op,
	input  wire logic [blitCorePkg::skewWidth-1:0] skew,
	input  wire logic direction,
	input  wire logic firstWord,
	input  wire logic lastWord,
	input  wire logic [blitRegsPkg::dataWidth-1:0] leftMask,
	input  wire logic [blitRegsPkg::dataWidth-1:0] centerMask,
	input  wire logic [blitRegsPkg::dataWidth-1:0] rightMask,
	output logic [blitRegsPkg::dataWidth-1:0] result,
	output logic partialMask
);
	import blitRegsPkg::*;
	import blitCorePkg::*;

	logic [2*dataWidth-1:0] skewBuf;	// Two most recent source words
	logic [2*dataWidth-1:0] shifted;
	logic [dataWidth-1:0] srcWord;
	logic [dataWidth-1:0] dstLatch;
	logic [dataWidth-1:0] mask;

	// Direction set means the source runs backwards, new words enter the high half
	always_ff @(posedge Clks) begin
		if (rst)
			skewBuf <= '0;
		else if (srcDone && direction)
			skewBuf <= {memRdData, skewBuf[2*dataWidth-1 -: dataWidth]};
		else if (srcDone)
			skewBuf <= {skewBuf[dataWidth-1:0], memRdData};
	end

	always_ff @(posedge Clks) begin
		if (dstRdDone)
			dstLatch <= memRdData;
	end

	assign shifted = skewBuf >> skew;
	assign srcWord = shifted[dataWidth-1:0];

	// Left mask wins on a one-word line
	always_comb begin
		if (firstWord)
			mask = leftMask;
		else if (lastWord)
			mask = rightMask;
		else
			mask = centerMask;
	end

	assign partialMask = ~&mask;

	always_comb begin
		for (int i = 0; i < dataWidth; i++) begin
			if (!mask[i])
				result[i] = dstLatch[i];	// Masked off, destination kept
			else if (srcWord[i])
				result[i] = dstLatch[i] ? op[opS1D1] : op[opS1D0];
			else
				result[i] = dstLatch[i] ? op[opS0D1] : op[opS0D0];
		end
	end

endmodule

`default_nettype wire

//--- src/blitSequencer.sv
// Bus cycle sequencer of the blitter.
// Runs source read, destination read and destination write per word as needed,
// holding each memory request until it is acknowledged.

`default_nettype none

module blitSequencer (
	input  wire logic Clks,
	input  wire logic rst,
	input  wire logic busy,
	input  wire logic newBlit,
	input  wire logic [blitCorePkg::opWidth-1:0] op,
	input  wire logic partialMask,
	input  wire logic memAck,
	input  wire logic [blitRegsPkg::addrWidth-1:0] srcAddr,
	input  wire logic [blitRegsPkg::addrWidth-1:0] dstAddr,
	input  wire logic [blitRegsPkg::dataWidth-1:0] result,
	output logic memReq,
	output logic memWe,
	output logic [blitRegsPkg::addrWidth-1:0] memAddr,
	output logic [blitRegsPkg::dataWidth-1:0] memWrData,
	output logic srcDone,
	output logic dstRdDone,
	output logic wrDone
);
	import blitCorePkg::*;

	blitState_t state;
	logic usesSrc;
	logic needDst;
	logic cycleEnd;

	// Ops 0, 5, A and F ignore the source; 0, 3, C and F ignore the destination
	assign usesSrc = (op[opS0D1] != op[opS1D1]) || (op[opS0D0] != op[opS1D0]);
	assign needDst = (op[opS0D0] != op[opS0D1]) || (op[opS1D0] != op[opS1D1]) || partialMask;
	assign cycleEnd = memReq && memAck;

	always_ff @(posedge Clks) begin
		if (rst || newBlit) begin
			state <= idle;
			memReq <= 1'b0;
		end else if (cycleEnd) begin
			memReq <= 1'b0;	// One idle cycle after every ack
			case (state)
				readSrc:  state <= needDst ? readDst : writeDst;
				readDst:  state <= writeDst;
				default:  state <= idle;	// Word written
			endcase
		end else if (state == idle) begin
			if (busy) begin
				state <= usesSrc ? readSrc : (needDst ? readDst : writeDst);
				memReq <= 1'b1;
			end
		end else if (!memReq) begin
			if (busy)
				memReq <= 1'b1;
			else
				state <= idle;	// Stopped by the CPU mid word
		end
	end

	assign srcDone = cycleEnd && state == readSrc;
	assign dstRdDone = cycleEnd && state == readDst;
	assign wrDone = cycleEnd && state == writeDst;

	assign memWe = memReq && state == writeDst;
	assign memAddr = (state == readSrc) ? srcAddr : dstAddr;
	assign memWrData = result;

	// Address may only move once the memory has taken the cycle
	addrHold: assert property (@(posedge Clks) disable iff (rst)
		(memReq && !memAck) |=> (memReq && $stable(memAddr)));

endmodule

`default_nettype wire

//--- src/blitAddrGen.sv
// Word counters and source/destination address registers of the blitter.
// Loaded by CPU writes, stepped by the sequencer's done pulses.
// Writing the Y count arms a new blit.

`default_nettype none

module blitAddrGen (
	input  wire logic Clks,
	input  wire logic rst,
	input  wire logic regWrEn,
	input  wire blitRegsPkg::regIdx_t cpuIdx,
	input  wire logic [blitRegsPkg::dataWidth-1:0] cpuWrData,
	input  wire logic [blitRegsPkg::dataWidth-1:0] srcXinc,
	input  wire logic [blitRegsPkg::dataWidth-1:0] srcYinc,
	input  wire logic [blitRegsPkg::dataWidth-1:0] dstXinc,
	input  wire logic [blitRegsPkg::dataWidth-1:0] dstYinc,
	input  wire logic srcDone,
	input  wire logic wrDone,
	output logic [blitRegsPkg::addrWidth-1:0] srcAddr,
	output logic [blitRegsPkg::addrWidth-1:0] dstAddr,
	output logic [blitRegsPkg::dataWidth-1:0] xCount,
	output logic [blitRegsPkg::dataWidth-1:0] yCount,
	output logic firstWord,
	output logic lastWord,
	output logic blitEnd,
	output logic newBlit
);
	import blitRegsPkg::*;

	logic [dataWidth-1:0] lineWidth;	// X count reload value
	logic [addrWidth-1:0] srcStep;
	logic [addrWidth-1:0] dstStep;
	logic yCountWr;

	// Byte increment to a sign-extended word step
	function automatic logic [addrWidth-1:0] wordStep(input logic [dataWidth-1:0] inc);
		return {{addrHiWidth{inc[dataWidth-1]}}, inc[dataWidth-1:1]};
	endfunction

	assign lastWord = xCount == 1;
	assign blitEnd = lastWord && yCount == 1;
	assign yCountWr = regWrEn && cpuIdx == regYCount;

	// Y increment applies on the last word of a line
	assign srcStep = wordStep(lastWord ? srcYinc : srcXinc);
	assign dstStep = wordStep(lastWord ? dstYinc : dstXinc);

	always_ff @(posedge Clks) begin
		if (rst) begin
			xCount <= '0;
			yCount <= '0;
		end else if (wrDone) begin
			if (lastWord) begin
				xCount <= lineWidth;
				yCount <= yCount - 1'b1;
			end else begin
				xCount <= xCount - 1'b1;
			end
		end else if (regWrEn) begin
			if (cpuIdx == regXCount)
				xCount <= cpuWrData;
			if (yCountWr)
				yCount <= cpuWrData;
		end
	end

	always_ff @(posedge Clks) begin
		if (regWrEn && cpuIdx == regXCount)
			lineWidth <= cpuWrData;
	end

	always_ff @(posedge Clks) begin
		if (srcDone)
			srcAddr <= srcAddr + srcStep;
		else if (regWrEn && cpuIdx == regSrcAddrHi)
			srcAddr[addrWidth-1 -: addrHiWidth] <= cpuWrData[addrHiWidth-1:0];
		else if (regWrEn && cpuIdx == regSrcAddrLo)
			srcAddr[dataWidth-2:0] <= cpuWrData[dataWidth-1:1];	// Byte bit 0 dropped

		if (wrDone)
			dstAddr <= dstAddr + dstStep;
		else if (regWrEn && cpuIdx == regDstAddrHi)
			dstAddr[addrWidth-1 -: addrHiWidth] <= cpuWrData[addrHiWidth-1:0];
		else if (regWrEn && cpuIdx == regDstAddrLo)
			dstAddr[dataWidth-2:0] <= cpuWrData[dataWidth-1:1];
	end

	always_ff @(posedge Clks) begin
		if (rst) begin
			newBlit <= 1'b0;
			firstWord <= 1'b0;
		end else begin
			newBlit <= yCountWr;
			if (yCountWr)
				firstWord <= 1'b1;
			else if (wrDone)
				firstWord <= lastWord;	// Next word opens a new line
		end
	end

	// Sequencer must never run a word past the end of a line
	xCountLive: assert property (@(posedge Clks) disable iff (rst)
		(srcDone || wrDone) |-> xCount != '0);

endmodule

`default_nettype wire

//--- src/blitRegisterFile.sv
// Blitter configuration registers as seen by the CPU.
// Holds increments, endmasks, op, skew and busy, and returns registered read data.
// Writes other than to the control register are dropped while a blit runs.

`default_nettype none

module blitRegisterFile (
	input  wire logic Clks,
	input  wire logic rst,
	input  wire logic cpuSel,
	input  wire logic cpuWr,
	input  wire blitRegsPkg::regIdx_t cpuIdx,
	input  wire logic [blitRegsPkg::dataWidth-1:0] cpuWrData,
	input  wire logic blitDone,
	input  wire logic [blitRegsPkg::addrWidth-1:0] srcAddr,
	input  wire logic [blitRegsPkg::addrWidth-1:0] dstAddr,
	input  wire logic [blitRegsPkg::dataWidth-1:0] xCount,
	input  wire logic [blitRegsPkg::dataWidth-1:0] yCount,
	output logic [blitRegsPkg::dataWidth-1:0] cpuRdData,
	output logic busy,
	output logic [blitCorePkg::opWidth-1:0] op,
	output logic [blitCorePkg::skewWidth-1:0] skew,
	output logic [blitRegsPkg::dataWidth-1:0] leftMask,
	output logic [blitRegsPkg::dataWidth-1:0] centerMask,
	output logic [blitRegsPkg::dataWidth-1:0] rightMask,
	output logic [blitRegsPkg::dataWidth-1:0] srcXinc,
	output logic [blitRegsPkg::dataWidth-1:0] srcYinc,
	output logic [blitRegsPkg::dataWidth-1:0] dstXinc,
	output logic [blitRegsPkg::dataWidth-1:0] dstYinc,
	output logic regWrEn
);
	import blitRegsPkg::*;
	import blitCorePkg::*;

	logic ctrlWr;
	logic [dataWidth-1:0] ctrlWord;
	logic [dataWidth-1:0] rdMux;

	assign regWrEn = cpuSel && cpuWr && (!busy || cpuIdx == regControl);
	assign ctrlWr = regWrEn && cpuIdx == regControl;

	always_ff @(posedge Clks) begin
		if (regWrEn) begin
			case (cpuIdx)
				regSrcXinc:    srcXinc <= cpuWrData;
				regSrcYinc:    srcYinc <= cpuWrData;
				regLeftMask:   leftMask <= cpuWrData;
				regCenterMask: centerMask <= cpuWrData;
				regRightMask:  rightMask <= cpuWrData;
				regDstXinc:    dstXinc <= cpuWrData;
				regDstYinc:    dstYinc <= cpuWrData;
				regOp:         op <= cpuWrData[opWidth-1:0];
				regControl:    skew <= cpuWrData[skewLsb +: skewWidth];
				default:       ;	// Addresses and counters live in the address generator
			endcase
		end
	end

	always_ff @(posedge Clks) begin
		if (rst)
			busy <= 1'b0;
		else if (ctrlWr)
			busy <= cpuWrData[ctrlBusyBit];	// Setting busy starts the engine
		else if (blitDone)
			busy <= 1'b0;
	end

	always_comb begin
		ctrlWord = '0;
		ctrlWord[ctrlBusyBit] = busy;
		ctrlWord[skewLsb +: skewWidth] = skew;
	end

	always_comb begin
		case (cpuIdx)
			regSrcXinc:    rdMux = srcXinc;
			regSrcYinc:    rdMux = srcYinc;
			regSrcAddrHi:  rdMux = {{(dataWidth - addrHiWidth){1'b0}},
				srcAddr[addrWidth-1 -: addrHiWidth]};
			regSrcAddrLo:  rdMux = {srcAddr[dataWidth-2:0], 1'b0};
			regLeftMask:   rdMux = leftMask;
			regCenterMask: rdMux = centerMask;
			regRightMask:  rdMux = rightMask;
			regDstXinc:    rdMux = dstXinc;
			regDstYinc:    rdMux = dstYinc;
			regDstAddrHi:  rdMux = {{(dataWidth - addrHiWidth){1'b0}},
				dstAddr[addrWidth-1 -: addrHiWidth]};
			regDstAddrLo:  rdMux = {dstAddr[dataWidth-2:0], 1'b0};
			regXCount:     rdMux = xCount;
			regYCount:     rdMux = yCount;
			regOp:         rdMux = {{(dataWidth - opWidth){1'b0}}, op};
			regControl:    rdMux = ctrlWord;
			default:       rdMux = '0;
		endcase
	end

	always_ff @(posedge Clks) begin
		if (rst)
			cpuRdData <= '0;
		else if (cpuSel && !cpuWr)
			cpuRdData <= rdMux;
	end

	// The end of a blit and a CPU control write must not land on the same edge
	ctrlVsDone: assert property (@(posedge Clks) disable iff (rst)
		!(cpuSel && cpuWr && cpuIdx == regControl && blitDone));

endmodule

`default_nettype wire

//--- src/blitCorePkg.sv
// Engine-side definitions: sequencer states and the logic operation code layout.
// Imported by the sequencer, the data path, the register file and the top level.

`default_nettype none

package blitCorePkg;

	// Kind of bus cycle pending or in flight
	typedef enum logic [1:0] {
		idle,
		readSrc,
		readDst,
		writeDst
	} blitState_t;

	localparam int opWidth = 4;
	localparam int skewWidth = 4;

	// Op code bit that gives the result for each source/destination bit pair
	localparam int opS0D0 = 3;
	localparam int opS0D1 = 2;
	localparam int opS1D0 = 1;
	localparam int opS1D1 = 0;

endpackage

`default_nettype wire

//--- src/blitRegsPkg.sv
// CPU-facing definitions for the blitter: word widths, register map and control bits.
// Imported by the register file, the address generator and the top level.

`default_nettype none

package blitRegsPkg;

	localparam int dataWidth = 16;	// CPU and memory data word
	localparam int addrWidth = 23;	// Word address, byte address bit 0 dropped
	localparam int addrHiWidth = addrWidth - dataWidth + 1;	// Bits held in the high address register

	typedef logic [3:0] regIdx_t;	// Register word index

	localparam regIdx_t regSrcXinc = 4'h0;
	localparam regIdx_t regSrcYinc = 4'h1;
	localparam regIdx_t regSrcAddrHi = 4'h2;
	localparam regIdx_t regSrcAddrLo = 4'h3;
	localparam regIdx_t regLeftMask = 4'h4;
	localparam regIdx_t regCenterMask = 4'h5;
	localparam regIdx_t regRightMask = 4'h6;
	localparam regIdx_t regDstXinc = 4'h7;
	localparam regIdx_t regDstYinc = 4'h8;
	localparam regIdx_t regDstAddrHi = 4'h9;
	localparam regIdx_t regDstAddrLo = 4'hA;
	localparam regIdx_t regXCount = 4'hB;
	localparam regIdx_t regYCount = 4'hC;
	localparam regIdx_t regOp = 4'hD;
	localparam regIdx_t regControl = 4'hE;	// Index F reads zero

	localparam int ctrlBusyBit = 15;	// Control register busy flag
	localparam int skewLsb = 0;	// Skew field starts here

endpackage

`default_nettype wire
